//--- design/io_hub_pkg.sv
/*
 * Shared widths, I/O register numbers and bus structs of the I/O hub.
 * Every block imports this package in its module header.
 */
package io_hub_pkg;

    typedef logic [31:0] word_t;    // bus data word
    typedef logic [7:0]  byte_t;    // uart byte
    typedef logic [4:0]  io_addr_t; // i/o word address, bus addr bits 6:2

    // register map as word addresses inside i/o space
    localparam io_addr_t REG_MS_COUNT  = 5'd0;
    localparam io_addr_t REG_LED       = 5'd1;
    localparam io_addr_t REG_UART_DATA = 5'd2;
    localparam io_addr_t REG_UART_STAT = 5'd3;
    localparam io_addr_t REG_SPI_DATA  = 5'd4;
    localparam io_addr_t REG_SPI_CTRL  = 5'd5;

    localparam logic [3:0] IO_SPACE_NIBBLE = 4'hE; // top nibble of i/o addresses

    // decoded processor access
    typedef struct packed {
        logic     io_en; // access falls in i/o space
        logic     wr;    // write access
        io_addr_t addr;  // word address
        word_t    wdata; // write data
    } io_req_t;

    // one-cycle write strobes, one per writable register
    typedef struct packed {
        logic led;
        logic uart_tx;
        logic uart_deq;
        logic spi_data;
        logic spi_ctrl;
    } io_wstb_t;

endpackage

//--- design/io_bus_decode.sv
/*
 * Input side of the I/O hub. Turns the processor bus into an I/O request
 * and combinational per-register write strobes.
 */
`timescale 1ns/1ps

module io_bus_decode import io_hub_pkg::*; (
    input  logic     cpu_sel_i,
    input  logic     cpu_we_i,
    input  word_t    cpu_addr_i,
    input  word_t    cpu_wdata_i,
    output io_req_t  req_o,
    output io_wstb_t wstb_o
);

    logic     io_en;
    logic     io_wr;
    io_addr_t io_addr;

    assign io_en   = cpu_sel_i && (cpu_addr_i[31:28] == IO_SPACE_NIBBLE);
    assign io_addr = cpu_addr_i[6:2]; // word address
    assign io_wr   = io_en && cpu_we_i;

    always_comb begin
        req_o.io_en = io_en;
        req_o.wr    = cpu_we_i;
        req_o.addr  = io_addr;
        req_o.wdata = cpu_wdata_i;
    end

    // a write to the status register pops the receive queue
    always_comb begin
        wstb_o.led      = io_wr && (io_addr == REG_LED);
        wstb_o.uart_tx  = io_wr && (io_addr == REG_UART_DATA);
        wstb_o.uart_deq = io_wr && (io_addr == REG_UART_STAT);
        wstb_o.spi_data = io_wr && (io_addr == REG_SPI_DATA);
        wstb_o.spi_ctrl = io_wr && (io_addr == REG_SPI_CTRL);
    end

endmodule

//--- design/ms_timer.sv
/*
 * Free-running millisecond counter. A cycle prescaler wraps every
 * FREQ_HZ/1000 clocks and advances the 32-bit count by one.
 */
`timescale 1ns/1ps

module ms_timer import io_hub_pkg::*; #(
    parameter int FREQ_HZ = 25_000_000
) (
    input  logic  clk_cpu,
    input  logic  rst_n,
    output word_t ms_count_o
);

    localparam int CYC_PER_MS = FREQ_HZ / 1000;
    localparam int PRE_W      = (CYC_PER_MS > 1) ? $clog2(CYC_PER_MS) : 1;

    logic [PRE_W-1:0] presc;
    logic             limit;

    assign limit = (presc == PRE_W'(CYC_PER_MS - 1)); // last cycle of the ms

    always_ff @(posedge clk_cpu) begin
        if (!rst_n) begin
            presc      <= '0;
            ms_count_o <= '0;
        end else begin
            if (limit) begin
                presc      <= '0;
                ms_count_o <= ms_count_o + word_t'(1);
            end else begin
                presc <= presc + PRE_W'(1);
            end
        end
    end

endmodule

//--- design/uart_rx_queue.sv
/*
 * Receive byte FIFO between the UART receiver and the processor.
 * Enqueues on each rising edge of rx_valid_i; a dequeue loads the received-byte register.
 */
`timescale 1ns/1ps

module uart_rx_queue import io_hub_pkg::*; #(
    parameter int RX_DEPTH_LOG2 = 10
) (
    input  logic  clk_cpu,
    input  logic  rst_n,
    input  byte_t rx_byte_i,
    input  logic  rx_valid_i,
    input  logic  deq_i,
    output byte_t rx_data_o,
    output logic  rx_ready_o
);

    localparam int DEPTH = 1 << RX_DEPTH_LOG2;

    byte_t mem [0:DEPTH-1];

    logic [RX_DEPTH_LOG2:0] wr_ptr; // extra bit tells full from empty
    logic [RX_DEPTH_LOG2:0] rd_ptr;
    logic                   valid_d;
    logic                   enq;
    byte_t                  enq_byte;
    logic                   empty;
    logic                   full;

    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[RX_DEPTH_LOG2] != rd_ptr[RX_DEPTH_LOG2]) &&
                   (wr_ptr[RX_DEPTH_LOG2-1:0] == rd_ptr[RX_DEPTH_LOG2-1:0]);

    assign rx_ready_o = !empty;

    // edge detect on the receiver level with the byte captured alongside
    always_ff @(posedge clk_cpu) begin
        if (!rst_n) begin
            valid_d <= 1'b0;
            enq     <= 1'b0;
        end else begin
            valid_d <= rx_valid_i;
            enq     <= rx_valid_i && !valid_d;
        end
    end

    always_ff @(posedge clk_cpu) begin
        if (rx_valid_i && !valid_d) begin
            enq_byte <= rx_byte_i;
        end
    end

    // storage
    always_ff @(posedge clk_cpu) begin
        if (enq && !full) begin
            mem[wr_ptr[RX_DEPTH_LOG2-1:0]] <= enq_byte;
        end
    end

    always_ff @(posedge clk_cpu) begin
        if (!rst_n) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            rx_data_o <= '0;
        end else begin
            if (enq && !full) begin
                wr_ptr <= wr_ptr + 1'b1; // overflow bytes are dropped
            end
            if (deq_i && !empty) begin
                rx_data_o <= mem[rd_ptr[RX_DEPTH_LOG2-1:0]]; // head into data reg
                rd_ptr    <= rd_ptr + 1'b1;
            end
        end
    end

endmodule

//--- design/io_ctrl_regs.sv
/*
 * LED and SPI control registers, plus the one-cycle UART transmit and
 * SPI start pulses registered together with their data.
 */
`timescale 1ns/1ps

module io_ctrl_regs import io_hub_pkg::*; (
    input  logic       clk_cpu,
    input  logic       rst_n,
    input  io_wstb_t   wstb_i,
    input  word_t      wdata_i,
    output byte_t      led_o,
    output logic [1:0] spi_ss_n_o,
    output logic       spi_fast_o,
    output logic       spi_start_o,
    output word_t      spi_tx_o,
    output logic       tx_start_o,
    output byte_t      tx_data_o
);

    logic [2:0] spi_ctrl; // fast flag, slave select 1, slave select 0

    assign spi_ss_n_o = ~spi_ctrl[1:0]; // selects are active low
    assign spi_fast_o = spi_ctrl[2];

    always_ff @(posedge clk_cpu) begin
        if (!rst_n) begin
            led_o       <= '0;
            spi_ctrl    <= '0;
            tx_start_o  <= 1'b0;
            spi_start_o <= 1'b0;
        end else begin
            tx_start_o  <= wstb_i.uart_tx;  // single cycle pulse
            spi_start_o <= wstb_i.spi_data;
            if (wstb_i.led) begin
                led_o <= wdata_i[7:0];
            end
            if (wstb_i.spi_ctrl) begin
                spi_ctrl <= wdata_i[2:0];
            end
        end
    end

    // data held until the next start
    always_ff @(posedge clk_cpu) begin
        if (wstb_i.uart_tx) begin
            tx_data_o <= wdata_i[7:0];
        end
        if (wstb_i.spi_data) begin
            spi_tx_o <= wdata_i;
        end
    end

endmodule

//--- design/io_read_mux.sv
/*
 * Output side of the I/O hub. Builds the processor read word from the
 * register number; zero outside I/O space and for unused registers.
 */
`timescale 1ns/1ps

module io_read_mux import io_hub_pkg::*; (
    input  io_req_t req_i,
    input  word_t   ms_count_i,
    input  byte_t   rx_data_i,
    input  logic    rx_ready_i,
    input  logic    tx_rdy_i,
    input  word_t   spi_rx_i,
    input  logic    spi_rdy_i,
    output word_t   rdata_o
);

    always_comb begin
        rdata_o = '0;
        if (req_i.io_en) begin
            case (req_i.addr)
                REG_MS_COUNT:  rdata_o = ms_count_i;
                REG_UART_DATA: rdata_o = word_t'(rx_data_i);
                REG_UART_STAT: rdata_o = {30'd0, tx_rdy_i, rx_ready_i}; // tx bit 1, rx bit 0
                REG_SPI_DATA:  rdata_o = spi_rx_i;
                REG_SPI_CTRL:  rdata_o = word_t'(spi_rdy_i);
                default:       rdata_o = '0; // led and unused regs
            endcase
        end
    end

endmodule

//--- design/io_hub.sv
/*
 * Top of the memory-mapped I/O register block. Wires bus decode, timer,
 * receive queue, control registers and read mux; parameters set here.
 */
`timescale 1ns/1ps

module io_hub import io_hub_pkg::*; #(
    parameter int FREQ_HZ       = 25_000_000,
    parameter int RX_DEPTH_LOG2 = 10
) (
    input  logic       clk_cpu,
    input  logic       rst_n,
    // processor bus
    input  logic       cpu_sel_i,
    input  logic       cpu_we_i,
    input  word_t      cpu_addr_i,
    input  word_t      cpu_wdata_i,
    output word_t      rdata_o,
    // uart
    input  byte_t      rx_byte_i,
    input  logic       rx_valid_i,
    input  logic       tx_rdy_i,
    output logic       tx_start_o,
    output byte_t      tx_data_o,
    // spi
    input  word_t      spi_rx_i,
    input  logic       spi_rdy_i,
    output logic       spi_start_o,
    output word_t      spi_tx_o,
    output logic [1:0] spi_ss_n_o,
    output logic       spi_fast_o,
    // board
    output byte_t      led_o
);

    io_req_t  io_req;
    io_wstb_t io_wstb;
    word_t    ms_count;
    byte_t    rx_data;
    logic     rx_ready;

    io_bus_decode i_io_bus_decode (
        .cpu_sel_i   (cpu_sel_i),
        .cpu_we_i    (cpu_we_i),
        .cpu_addr_i  (cpu_addr_i),
        .cpu_wdata_i (cpu_wdata_i),
        .req_o       (io_req),
        .wstb_o      (io_wstb)
    );

    ms_timer #(
        .FREQ_HZ (FREQ_HZ)
    ) i_ms_timer (
        .clk_cpu    (clk_cpu),
        .rst_n      (rst_n),
        .ms_count_o (ms_count)
    );

    uart_rx_queue #(
        .RX_DEPTH_LOG2 (RX_DEPTH_LOG2)
    ) i_uart_rx_queue (
        .clk_cpu    (clk_cpu),
        .rst_n      (rst_n),
        .rx_byte_i  (rx_byte_i),
        .rx_valid_i (rx_valid_i),
        .deq_i      (io_wstb.uart_deq),
        .rx_data_o  (rx_data),
        .rx_ready_o (rx_ready)
    );

    io_ctrl_regs i_io_ctrl_regs (
        .clk_cpu     (clk_cpu),
        .rst_n       (rst_n),
        .wstb_i      (io_wstb),
        .wdata_i     (io_req.wdata),
        .led_o       (led_o),
        .spi_ss_n_o  (spi_ss_n_o),
        .spi_fast_o  (spi_fast_o),
        .spi_start_o (spi_start_o),
        .spi_tx_o    (spi_tx_o),
        .tx_start_o  (tx_start_o),
        .tx_data_o   (tx_data_o)
    );

    io_read_mux i_io_read_mux (
        .req_i      (io_req),
        .ms_count_i (ms_count),
        .rx_data_i  (rx_data),
        .rx_ready_i (rx_ready),
        .tx_rdy_i   (tx_rdy_i),
        .spi_rx_i   (spi_rx_i),
        .spi_rdy_i  (spi_rdy_i),
        .rdata_o    (rdata_o)
    );

endmodule

//--- bench/tb_io_hub.sv
/*
 * Testbench for the I/O hub. Plays the operations of the vector file
 * against the DUT, checks reads and outputs, and closes with a summary.
 */
`timescale 1ns/1ps

module tb_io_hub;
    import io_hub_pkg::*;

    localparam int    FREQ_HZ    = 10_000;
    localparam int    CYC_PER_MS = FREQ_HZ / 1000;
    localparam int    CLK_PERIOD = 10;
    localparam int    RESET_CYC  = 5;
    localparam string VEC_FILE   = "bench/io_hub_vectors.txt";

    logic       clk_cpu;
    logic       rst_n;
    logic       cpu_sel;
    logic       cpu_we;
    word_t      cpu_addr;
    word_t      cpu_wdata;
    word_t      rdata;
    byte_t      rx_byte;
    logic       rx_valid;
    logic       tx_rdy;
    logic       tx_start;
    byte_t      tx_data;
    word_t      spi_rx;
    logic       spi_rdy;
    logic       spi_start;
    word_t      spi_tx;
    logic [1:0] spi_ss_n;
    logic       spi_fast;
    byte_t      led;

    logic [7:0] vec_op   [$];
    word_t      vec_addr [$];
    word_t      vec_data [$];
    word_t      vec_exp  [$];
    int         errors;
    int         cycles;     // rising edges since reset release
    int         idle_total;
    bit         loaded;

    io_hub #(
        .FREQ_HZ       (FREQ_HZ),
        .RX_DEPTH_LOG2 (2)
    ) i_io_hub (
        .clk_cpu     (clk_cpu),
        .rst_n       (rst_n),
        .cpu_sel_i   (cpu_sel),
        .cpu_we_i    (cpu_we),
        .cpu_addr_i  (cpu_addr),
        .cpu_wdata_i (cpu_wdata),
        .rdata_o     (rdata),
        .rx_byte_i   (rx_byte),
        .rx_valid_i  (rx_valid),
        .tx_rdy_i    (tx_rdy),
        .tx_start_o  (tx_start),
        .tx_data_o   (tx_data),
        .spi_rx_i    (spi_rx),
        .spi_rdy_i   (spi_rdy),
        .spi_start_o (spi_start),
        .spi_tx_o    (spi_tx),
        .spi_ss_n_o  (spi_ss_n),
        .spi_fast_o  (spi_fast),
        .led_o       (led)
    );

    initial begin
        clk_cpu = 1'b0;
        forever #(CLK_PERIOD / 2) clk_cpu = ~clk_cpu;
    end

    always @(posedge clk_cpu) begin
        if (rst_n) begin
            cycles <= cycles + 1;
        end
    end

    task automatic bus_idle();
        cpu_sel   = 1'b0;
        cpu_we    = 1'b0;
        cpu_addr  = '0;
        cpu_wdata = '0;
    endtask

    task automatic compare(input string name, input word_t exp, input word_t got);
        if (got !== exp) begin
            errors++;
            $display("MISMATCH at %0d ns: %s expected %h, got %h", $time, name, exp, got);
        end
    endtask

    // read data is combinational and sampled well before the next edge
    task automatic read_check(input word_t addr, input word_t exp);
        cpu_sel  = 1'b1;
        cpu_addr = addr;
        #2;
        compare("rdata_o", exp, rdata);
    endtask

    task automatic output_check(input word_t sel, input word_t exp);
        case (sel)
            0: compare("led_o", exp, word_t'(led));
            1: compare("spi_ss_n_o", exp, word_t'(spi_ss_n));
            2: compare("spi_fast_o", exp, word_t'(spi_fast));
            3: compare("tx_start_o", exp, word_t'(tx_start));
            4: compare("tx_data_o", exp, word_t'(tx_data));
            5: compare("spi_start_o", exp, word_t'(spi_start));
            6: compare("spi_tx_o", exp, spi_tx);
            default: begin
                errors++;
                $display("vector file names an unknown output %0d", sel);
            end
        endcase
    endtask

    task automatic set_level(input word_t sel, input word_t value);
        case (sel)
            0: tx_rdy = value[0];
            1: spi_rx = value;
            2: spi_rdy = value[0];
            default: begin
                errors++;
                $display("vector file names an unknown input level %0d", sel);
            end
        endcase
    endtask

    task automatic load_vectors();
        int         fd;
        int         n;
        string      line;
        logic [7:0] op;
        word_t      a;
        word_t      d;
        word_t      e;
        fd = $fopen(VEC_FILE, "r");
        if (fd == 0) begin
            errors++;
            $display("could not open the vector file %s", VEC_FILE);
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            if (n > 0 && line.len() > 1 && line[0] != "#") begin
                n = $sscanf(line, "%c %h %h %h", op, a, d, e);
                if (n == 4) begin
                    vec_op.push_back(op);
                    vec_addr.push_back(a);
                    vec_data.push_back(d);
                    vec_exp.push_back(e);
                    if (op == "I") begin
                        idle_total += int'(d);
                    end
                end else begin
                    errors++;
                    $display("vector file line could not be parsed: %s", line);
                end
            end
        end
        $fclose(fd);
    endtask

    // every operation starts on a falling edge
    task automatic play_vector(input int i);
        @(negedge clk_cpu);
        bus_idle();
        case (vec_op[i])
            "W": begin
                cpu_sel   = 1'b1;
                cpu_we    = 1'b1;
                cpu_addr  = vec_addr[i];
                cpu_wdata = vec_data[i];
            end
            "R": read_check(vec_addr[i], vec_exp[i]);
            "T": read_check(vec_addr[i], word_t'(cycles / CYC_PER_MS)); // 10 cycles per ms
            "P": begin
                rx_byte  = vec_data[i][7:0];
                rx_valid = 1'b1;
                @(negedge clk_cpu);
                rx_valid = 1'b0;
            end
            "L": set_level(vec_addr[i], vec_data[i]);
            "C": output_check(vec_addr[i], vec_exp[i]);
            "I": repeat (vec_data[i]) @(negedge clk_cpu);
            default: begin
                errors++;
                $display("vector %0d has an unknown operation %c", i, vec_op[i]);
            end
        endcase
    endtask

    initial begin : watchdog
        wait (loaded);
        #((vec_op.size() * 20 + idle_total + RESET_CYC) * CLK_PERIOD);
        $display("timeout, the vectors did not finish in time");
        $display("Errors found");
        $finish;
    end

    initial begin
        errors     = 0;
        cycles     = 0;
        idle_total = 0;
        loaded     = 1'b0;
        rst_n      = 1'b0;
        rx_byte    = '0;
        rx_valid   = 1'b0;
        tx_rdy     = 1'b0;
        spi_rx     = '0;
        spi_rdy    = 1'b0;
        bus_idle();
        load_vectors();
        loaded = 1'b1;
        repeat (RESET_CYC) @(posedge clk_cpu);
        @(negedge clk_cpu);
        rst_n = 1'b1;
        for (int i = 0; i < vec_op.size(); i++) begin
            play_vector(i);
        end
        @(negedge clk_cpu);
        bus_idle();
        $display("%0d vectors played, %0d errors", vec_op.size(), errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

//--- io_hub.f
design/io_hub_pkg.sv
design/io_bus_decode.sv
design/ms_timer.sv
design/uart_rx_queue.sv
design/io_ctrl_regs.sv
design/io_read_mux.sv
design/io_hub.sv
bench/tb_io_hub.sv

//--- Makefile
# Verilator flow for the I/O hub: lint, simulate, clean.
# Any variable can be overridden, e.g. make sim LOG=run.log

VERILATOR ?= verilator
TOP       ?= tb_io_hub
RTL_TOP   ?= io_hub
FILELIST  ?= io_hub.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal
FAIL_MSG  ?= Errors found
PASS_MSG  ?= No errors

SOURCES := $(shell cat $(FILELIST))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(RTL_TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

sim: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "simulation did not complete"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- bench/io_hub_vectors.txt
# op addr data expect, all hex. W write, R read/compare, T timer read, P push rx byte,
# L level (addr 0 tx_rdy, 1 spi_rx, 2 spi_rdy), C output check (addr picks output), I idle
C 0 0 0
C 1 0 3
C 3 0 0
C 5 0 0
R E000000C 0 0
W E0000004 A5 0
C 0 0 A5
R E0000004 0 0
W 00000004 3C 0
C 0 0 A5
R 00000004 0 0
R 00000000 0 0
T E0000000 0 0
I 0 7 0
T E0000000 0 0
I 0 19 0
T E0000000 0 0
P 0 11 0
P 0 22 0
P 0 33 0
P 0 44 0
P 0 55 0
R E000000C 0 1
R E0000008 0 0
W E000000C 0 0
R E0000008 0 11
W E000000C 0 0
R E0000008 0 22
W E000000C 0 0
R E0000008 0 33
R E000000C 0 1
W E000000C 0 0
R E0000008 0 44
R E000000C 0 0
W E000000C 0 0
R E0000008 0 44
W E0000008 1234 0
C 3 0 1
C 3 0 0
C 4 0 34
L 0 1 0
R E000000C 0 2
W E0000014 5 0
C 1 0 2
C 2 0 1
W E0000014 2 0
C 1 0 1
C 2 0 0
W E0000010 DEADBEEF 0
C 5 0 1
C 5 0 0
C 6 0 DEADBEEF
L 1 CAFE0001 0
L 2 1 0
R E0000010 0 CAFE0001
R E0000014 0 1
R E0000018 0 0
T E0000000 0 0
